/* isaPkg.sv */
package isaPkg;

	// raw byte from the instruction bus.
	typedef logic [7:0] opcodeT;

	// first state of each instruction equals its opcode.
	typedef enum logic [7:0] {
		ENDOP    = 8'h01,
		// register resets.
		RSTALL   = 8'h10,
		RSTAC    = 8'h11,
		RSTADDR  = 8'h12,
		RSTGSP   = 8'h13,
		RSTMC    = 8'h14,
		RSTCP    = 8'h15,
		RSTRP    = 8'h16,
		// register increments.
		INCGSP   = 8'h20,
		INCAC    = 8'h21,
		INCCP    = 8'h22,
		INCRP    = 8'h23,
		INCMC    = 8'h24,
		INCSTP   = 8'h25,
		// loads and stack store.
		LDADDR_1 = 8'h30,
		LDAC_1   = 8'h31,
		LDMULR_1 = 8'h32,
		LDRP_1   = 8'h33,
		LDCP_1   = 8'h34,
		STSP_1   = 8'h35,
		ADD      = 8'h40,
		MUL1     = 8'h41,
		MUL2     = 8'h42,
		DIV      = 8'h43,
		MOD      = 8'h44,
		// moves out of AC.
		MSTP     = 8'h50,
		MRP      = 8'h51,
		MCP      = 8'h52,
		MWV      = 8'h53,
		MEOPC    = 8'h54,
		MADDR    = 8'h55,
		MCID     = 8'h56,
		MMV      = 8'h57,
		// moves into AC.
		MCIDAC   = 8'h60,
		MRPAC    = 8'h61,
		MCPAC    = 8'h62,
		MSTPAC   = 8'h63,
		JMPZ1    = 8'h70,
		JMPZ2    = 8'h71,
		// continuation states, never fetched as opcodes.
		LDADDR_2 = 8'hB0,
		LDAC_2   = 8'hB1,
		LDMULR_2 = 8'hB2,
		LDRP_2   = 8'hB3,
		LDCP_2   = 8'hB4,
		JMPZ1Y_1 = 8'hC0,
		JMPZ1Y_2 = 8'hC1,
		JMPZ1Y_3 = 8'hC2,
		JMPZ1N_1 = 8'hC4,
		JMPZ1N_2 = 8'hC5,
		JMPZ2Y_1 = 8'hD0,
		JMPZ2Y_2 = 8'hD1,
		JMPZ2Y_3 = 8'hD2,
		JMPZ2N_1 = 8'hD4,
		JMPZ2N_2 = 8'hD5,
		FETCH_1  = 8'hF0,
		FETCH_2  = 8'hF1
	} stateT;

endpackage

/* ctrlPkg.sv */
package ctrlPkg;

	localparam int NumRegs = 14;

	// bit position of each register in the enable masks.
	typedef enum logic [3:0] {
		REG_PC   = 4'd0,
		REG_IR   = 4'd1,
		REG_GSP  = 4'd2,
		REG_RP   = 4'd3,
		REG_CP   = 4'd4,
		REG_STP  = 4'd5,
		REG_CID  = 4'd6,
		REG_EOPC = 4'd7,
		REG_MC   = 4'd8,
		REG_MV   = 4'd9,
		REG_WV   = 4'd10,
		REG_MULR = 4'd11,
		REG_ADDR = 4'd12,
		REG_AC   = 4'd13
	} regIdxT;

	typedef enum logic [2:0] {
		ALU_NONE, ALU_ADD, ALU_MUL, ALU_DIV, ALU_MOD
	} aluOpT;

	typedef enum logic [3:0] {
		BS_AC, BS_MEMOUT, BS_ADDR, BS_MULR, BS_MV,
		BS_WV, BS_CID, BS_RP, BS_CP, BS_STP
	} busSelT;

	typedef enum logic [1:0] {
		P_GSP, P_RP, P_CP, P_STP
	} ptrSelT;

	typedef enum logic [3:0] {
		MEM_IDLE, MEM_IREAD, MEM_READ, MEM_WRITE
	} memCtrlT;

	// STEPPC is the fetch step, PC increment plus IR write.
	typedef enum logic [2:0] {
		ROP_NONE, ROP_WRITE, ROP_INC, ROP_RST, ROP_RSTALL, ROP_STEPPC
	} regOpT;

	typedef struct packed {
		aluOpT   aluOp;
		busSelT  busSel;
		ptrSelT  ptrSel;
		memCtrlT memCtrl;
	} busCtrlT;

	typedef struct packed {
		busCtrlT busCtrl;
		regOpT   regOp;
		regIdxT  regSel;
	} ctrlWordT;

	typedef struct packed {
		logic [NumRegs-1:0] wrtEn;
		logic [NumRegs-1:0] incEn;
		logic [NumRegs-1:0] rstEn;
	} regEnT;

endpackage

/* stateSequencer.sv */
module stateSequencer
	import isaPkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  opcodeT ins,
	input  logic   z1,
	input  logic   z2,
	output stateT  state
);

	stateT nextState;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= FETCH_1;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = FETCH_1; // single-step ops and final states.
		case (state)
			FETCH_1:  nextState = FETCH_2;
			FETCH_2:  nextState = stateT'(ins); // opcode is the next state.
			ENDOP:    nextState = ENDOP; // held until reset.
			LDADDR_1: nextState = LDADDR_2;
			LDAC_1:   nextState = LDAC_2;
			LDMULR_1: nextState = LDMULR_2;
			LDRP_1:   nextState = LDRP_2;
			LDCP_1:   nextState = LDCP_2;
			JMPZ1: begin
				if (z1) begin
					nextState = JMPZ1Y_1;
				end else begin
					nextState = JMPZ1N_1;
				end
			end
			JMPZ2: begin
				// taken on a clear z2.
				if (!z2) begin
					nextState = JMPZ2Y_1;
				end else begin
					nextState = JMPZ2N_1;
				end
			end
			JMPZ1Y_1: nextState = JMPZ1Y_2;
			JMPZ1Y_2: nextState = JMPZ1Y_3;
			JMPZ1N_1: nextState = JMPZ1N_2;
			JMPZ2Y_1: nextState = JMPZ2Y_2;
			JMPZ2Y_2: nextState = JMPZ2Y_3;
			JMPZ2N_1: nextState = JMPZ2N_2;
			default:  nextState = FETCH_1;
		endcase
	end

	property pResetToFetch;
		@(posedge clk) !rstN |=> state == FETCH_1;
	endproperty

	property pHaltHolds;
		@(posedge clk) (state == ENDOP) && rstN |=> state == ENDOP;
	endproperty

	assert property (pResetToFetch)
		else $error("state not FETCH_1 after reset");

	assert property (pHaltHolds)
		else $error("left ENDOP without reset");

endmodule

/* microcodeRom.sv */
module microcodeRom
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  stateT   state,
	output busCtrlT busCtrl,
	output regOpT   regOp,
	output regIdxT  regSel
);

	ctrlWordT cw;

	function automatic ctrlWordT makeWord(
		input aluOpT   alu,
		input busSelT  src,
		input ptrSelT  ptr,
		input memCtrlT mem,
		input regOpT   op,
		input regIdxT  sel
	);
		ctrlWordT w;
		w.busCtrl.aluOp   = alu;
		w.busCtrl.busSel  = src;
		w.busCtrl.ptrSel  = ptr;
		w.busCtrl.memCtrl = mem;
		w.regOp           = op;
		w.regSel          = sel;
		return w;
	endfunction

	// idle bus, only a register micro-op.
	function automatic ctrlWordT regWord(input regOpT op, input regIdxT sel);
		return makeWord(ALU_NONE, BS_AC, P_GSP, MEM_IDLE, op, sel);
	endfunction

	always_comb begin
		case (state)
			FETCH_1:  cw = makeWord(ALU_NONE, BS_AC, P_GSP, MEM_IREAD, ROP_NONE, REG_PC);
			FETCH_2:  cw = makeWord(ALU_NONE, BS_AC, P_GSP, MEM_IREAD, ROP_STEPPC, REG_PC);
			RSTALL:   cw = regWord(ROP_RSTALL, REG_PC);
			RSTAC:    cw = regWord(ROP_RST, REG_AC);
			RSTADDR:  cw = regWord(ROP_RST, REG_ADDR);
			RSTGSP:   cw = regWord(ROP_RST, REG_GSP);
			RSTMC:    cw = regWord(ROP_RST, REG_MC);
			RSTCP:    cw = regWord(ROP_RST, REG_CP);
			RSTRP:    cw = regWord(ROP_RST, REG_RP);
			INCGSP:   cw = regWord(ROP_INC, REG_GSP);
			INCAC:    cw = regWord(ROP_INC, REG_AC);
			INCCP:    cw = regWord(ROP_INC, REG_CP);
			INCRP:    cw = regWord(ROP_INC, REG_RP);
			INCMC:    cw = regWord(ROP_INC, REG_MC);
			INCSTP:   cw = regWord(ROP_INC, REG_STP);
			LDADDR_1,
			LDAC_1,
			LDMULR_1: cw = makeWord(ALU_NONE, BS_AC, P_GSP, MEM_READ, ROP_NONE, REG_PC);
			LDRP_1:   cw = makeWord(ALU_NONE, BS_AC, P_RP, MEM_READ, ROP_NONE, REG_PC);
			LDCP_1:   cw = makeWord(ALU_NONE, BS_AC, P_CP, MEM_READ, ROP_NONE, REG_PC);
			// second load step takes the memory word off the bus.
			LDADDR_2: cw = makeWord(ALU_NONE, BS_MEMOUT, P_GSP, MEM_IDLE, ROP_WRITE, REG_ADDR);
			LDAC_2,
			LDCP_2:   cw = makeWord(ALU_NONE, BS_MEMOUT, P_GSP, MEM_IDLE, ROP_WRITE, REG_AC);
			LDMULR_2,
			LDRP_2:   cw = makeWord(ALU_NONE, BS_MEMOUT, P_GSP, MEM_IDLE, ROP_WRITE, REG_MULR);
			STSP_1:   cw = makeWord(ALU_NONE, BS_AC, P_STP, MEM_WRITE, ROP_NONE, REG_PC);
			ADD:      cw = makeWord(ALU_ADD, BS_ADDR, P_GSP, MEM_IDLE, ROP_NONE, REG_PC);
			MUL1:     cw = makeWord(ALU_MUL, BS_MULR, P_GSP, MEM_IDLE, ROP_NONE, REG_PC);
			MUL2:     cw = makeWord(ALU_MUL, BS_MV, P_GSP, MEM_IDLE, ROP_NONE, REG_PC);
			DIV:      cw = makeWord(ALU_DIV, BS_WV, P_GSP, MEM_IDLE, ROP_NONE, REG_PC);
			MOD:      cw = makeWord(ALU_MOD, BS_WV, P_GSP, MEM_IDLE, ROP_NONE, REG_PC);
			MSTP:     cw = regWord(ROP_WRITE, REG_STP);
			MRP:      cw = regWord(ROP_WRITE, REG_RP);
			MCP:      cw = regWord(ROP_WRITE, REG_CP);
			MWV:      cw = regWord(ROP_WRITE, REG_WV);
			MEOPC:    cw = regWord(ROP_WRITE, REG_EOPC);
			MADDR:    cw = regWord(ROP_WRITE, REG_ADDR);
			MCID:     cw = regWord(ROP_WRITE, REG_CID);
			MMV:      cw = regWord(ROP_WRITE, REG_MV);
			MCIDAC:   cw = makeWord(ALU_NONE, BS_CID, P_GSP, MEM_IDLE, ROP_WRITE, REG_AC);
			MRPAC:    cw = makeWord(ALU_NONE, BS_RP, P_GSP, MEM_IDLE, ROP_WRITE, REG_AC);
			MCPAC:    cw = makeWord(ALU_NONE, BS_CP, P_GSP, MEM_IDLE, ROP_WRITE, REG_AC);
			MSTPAC:   cw = makeWord(ALU_NONE, BS_STP, P_GSP, MEM_IDLE, ROP_WRITE, REG_AC);
			JMPZ1Y_1,
			JMPZ2Y_1: cw = regWord(ROP_WRITE, REG_IR);
			JMPZ1Y_2,
			JMPZ2Y_2: cw = regWord(ROP_WRITE, REG_PC); // jump target into PC.
			JMPZ1N_1,
			JMPZ2N_1: cw = regWord(ROP_STEPPC, REG_PC); // skip the target word.
			default:  cw = regWord(ROP_NONE, REG_PC); // ENDOP, JMPZ and tails.
		endcase
	end

	assign busCtrl = cw.busCtrl;
	assign regOp   = cw.regOp;
	assign regSel  = cw.regSel;

	// stores go through the stack pointer only.
	assert final (busCtrl.memCtrl != MEM_WRITE || busCtrl.ptrSel == P_STP)
		else $error("memory write without STP pointer");

endmodule

/* regEnableDecoder.sv */
module regEnableDecoder
	import ctrlPkg::*;
(
	input  regOpT  regOp,
	input  regIdxT regSel,
	output regEnT  regEn
);

	localparam logic [NumRegs-1:0] RstAllMask = {{(NumRegs-2){1'b1}}, 2'b00}; // AC down to GSP.

	logic [NumRegs-1:0] selMask;

	assign selMask = {{(NumRegs-1){1'b0}}, 1'b1} << regSel;

	always_comb begin
		regEn = '0;
		case (regOp)
			ROP_WRITE:  regEn.wrtEn = selMask;
			ROP_INC:    regEn.incEn = selMask;
			ROP_RST:    regEn.rstEn = selMask;
			ROP_RSTALL: regEn.rstEn = RstAllMask;
			ROP_STEPPC: begin
				regEn.incEn[REG_PC] = 1'b1;
				regEn.wrtEn[REG_IR] = 1'b1;
			end
			default:    regEn = '0;
		endcase
	end

	// one action per register per cycle.
	assert final (((regEn.wrtEn & regEn.incEn) |
		(regEn.wrtEn & regEn.rstEn) |
		(regEn.incEn & regEn.rstEn)) == '0)
		else $error("register enabled in more than one mask");

endmodule

/* controlUnit.sv */
module controlUnit
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  opcodeT  ins,
	input  logic    z1,
	input  logic    z2,
	output busCtrlT busCtrl,
	output regEnT   regEn
);

	stateT  state;
	regOpT  regOp;
	regIdxT regSel;

	stateSequencer sequencer (
		.clk   (clk),
		.rstN  (rstN),
		.ins   (ins),
		.z1    (z1),
		.z2    (z2),
		.state (state)
	);

	microcodeRom rom (
		.state   (state),
		.busCtrl (busCtrl),
		.regOp   (regOp),
		.regSel  (regSel)
	);

	regEnableDecoder decoder (
		.regOp  (regOp),
		.regSel (regSel),
		.regEn  (regEn)
	);

endmodule

/* tbChecks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int errCount = 0;
int testCount = 0;
int failCount = 0;

task automatic checkBusCtrl(input busCtrlT exp, input busCtrlT act, input string msg);
	if (act !== exp) begin
		errCount++;
		$display("MISMATCH at %0t: %s busCtrl expected %h got %h", $time, msg, exp, act);
	end
endtask

task automatic checkRegEn(input regEnT exp, input regEnT act, input string msg);
	if (act !== exp) begin
		errCount++;
		$display("MISMATCH at %0t: %s regEn expected wrt %h inc %h rst %h got wrt %h inc %h rst %h",
			$time, msg, exp.wrtEn, exp.incEn, exp.rstEn, act.wrtEn, act.incEn, act.rstEn);
	end
endtask

// one line per test, errors counted since it started.
task automatic finishTest(input string name, input int errsAtStart);
	testCount++;
	if (errCount > errsAtStart) begin
		failCount++;
		$display("%s: failed with %0d errors", name, errCount - errsAtStart);
	end else begin
		$display("%s: ok", name);
	end
endtask

`endif

/* tbControlUnit.sv */
module tbControlUnit
	import isaPkg::*;
	import ctrlPkg::*;
();

	logic    clk;
	logic    rstN;
	opcodeT  ins;
	logic    z1;
	logic    z2;
	busCtrlT busCtrl;
	regEnT   regEn;
	int      seed = 32'h62b37e34;

	`include "tbChecks.svh"

	controlUnit UUT (
		.clk     (clk),
		.rstN    (rstN),
		.ins     (ins),
		.z1      (z1),
		.z2      (z2),
		.busCtrl (busCtrl),
		.regEn   (regEn)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic busCtrlT mkBus(aluOpT a, busSelT s, ptrSelT p, memCtrlT m);
		busCtrlT b;
		b.aluOp = a;
		b.busSel = s;
		b.ptrSel = p;
		b.memCtrl = m;
		return b;
	endfunction

	function automatic logic [NumRegs-1:0] bitOf(regIdxT r);
		return 1 << r;
	endfunction

	function automatic regEnT mkEn(logic [NumRegs-1:0] w, logic [NumRegs-1:0] i,
		logic [NumRegs-1:0] r);
		regEnT e;
		e.wrtEn = w;
		e.incEn = i;
		e.rstEn = r;
		return e;
	endfunction

	localparam busCtrlT IdleBus = '{ALU_NONE, BS_AC, P_GSP, MEM_IDLE};
	localparam busCtrlT FetchBus = '{ALU_NONE, BS_AC, P_GSP, MEM_IREAD};

	task automatic applyReset();
		@(posedge clk);
		rstN <= 1'b0;
		repeat (16) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
	endtask

	// FETCH_1 shows IREAD with no enables.
	task automatic waitFetch();
		int n;
		n = 0;
		while (!(busCtrl === FetchBus && regEn === '0) && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (!(busCtrl === FetchBus && regEn === '0)) begin
			errCount++;
			$display("timeout at %0t: FETCH_1 was never reached within 20 cycles", $time);
		end
	endtask

	// leaves the caller at the first state of the opcode.
	task automatic startOp(input opcodeT op, input logic f1, input logic f2);
		waitFetch();
		@(posedge clk);
		ins <= op;
		z1 <= f1;
		z2 <= f2;
		@(negedge clk);
		checkBusCtrl(FetchBus, busCtrl, "fetch 2");
		checkRegEn(mkEn(bitOf(REG_IR), bitOf(REG_PC), '0), regEn, "fetch 2");
		@(negedge clk);
	endtask

	task automatic expectFetch(input string msg);
		@(negedge clk);
		checkBusCtrl(FetchBus, busCtrl, msg);
		checkRegEn('0, regEn, msg);
	endtask

	task automatic runOp(input opcodeT op, input busCtrlT eb, input regEnT ee, input string msg);
		startOp(op, 1'b0, 1'b0);
		checkBusCtrl(eb, busCtrl, msg);
		checkRegEn(ee, regEn, msg);
		expectFetch({msg, " return"});
	endtask

	task automatic runLoad(input opcodeT op, input ptrSelT p, input regIdxT dst,
		input string msg);
		startOp(op, 1'b0, 1'b0);
		checkBusCtrl(mkBus(ALU_NONE, BS_AC, p, MEM_READ), busCtrl, msg);
		checkRegEn('0, regEn, msg);
		@(negedge clk);
		checkBusCtrl(mkBus(ALU_NONE, BS_MEMOUT, P_GSP, MEM_IDLE), busCtrl, msg);
		checkRegEn(mkEn(bitOf(dst), '0, '0), regEn, msg);
		expectFetch({msg, " return"});
	endtask

	task automatic runJump(input opcodeT op, input logic f1, input logic f2, input logic taken,
		input string msg);
		startOp(op, f1, f2);
		checkRegEn('0, regEn, msg);
		@(negedge clk);
		checkBusCtrl(IdleBus, busCtrl, msg);
		if (taken) begin
			checkRegEn(mkEn(bitOf(REG_IR), '0, '0), regEn, {msg, " ir"});
			@(negedge clk);
			checkRegEn(mkEn(bitOf(REG_PC), '0, '0), regEn, {msg, " pc"});
		end else begin
			checkRegEn(mkEn(bitOf(REG_IR), bitOf(REG_PC), '0), regEn, {msg, " skip"});
		end
		@(negedge clk);
		checkRegEn('0, regEn, {msg, " tail"});
		expectFetch({msg, " return"});
	endtask

	task automatic testFetch();
		int e0;
		e0 = errCount;
		applyReset();
		checkBusCtrl(FetchBus, busCtrl, "fetch 1");
		checkRegEn('0, regEn, "fetch 1");
		@(negedge clk);
		checkBusCtrl(FetchBus, busCtrl, "fetch 2");
		checkRegEn(mkEn(bitOf(REG_IR), bitOf(REG_PC), '0), regEn, "fetch 2");
		finishTest("fetch", e0);
	endtask

	task automatic testRegOps();
		int e0;
		e0 = errCount;
		runOp(RSTALL, IdleBus, mkEn('0, '0, 14'h3FFC), "rstall");
		runOp(RSTAC, IdleBus, mkEn('0, '0, bitOf(REG_AC)), "rstac");
		runOp(RSTADDR, IdleBus, mkEn('0, '0, bitOf(REG_ADDR)), "rstaddr");
		runOp(RSTGSP, IdleBus, mkEn('0, '0, bitOf(REG_GSP)), "rstgsp");
		runOp(RSTMC, IdleBus, mkEn('0, '0, bitOf(REG_MC)), "rstmc");
		runOp(RSTCP, IdleBus, mkEn('0, '0, bitOf(REG_CP)), "rstcp");
		runOp(RSTRP, IdleBus, mkEn('0, '0, bitOf(REG_RP)), "rstrp");
		runOp(INCGSP, IdleBus, mkEn('0, bitOf(REG_GSP), '0), "incgsp");
		runOp(INCAC, IdleBus, mkEn('0, bitOf(REG_AC), '0), "incac");
		runOp(INCCP, IdleBus, mkEn('0, bitOf(REG_CP), '0), "inccp");
		runOp(INCRP, IdleBus, mkEn('0, bitOf(REG_RP), '0), "incrp");
		runOp(INCMC, IdleBus, mkEn('0, bitOf(REG_MC), '0), "incmc");
		runOp(INCSTP, IdleBus, mkEn('0, bitOf(REG_STP), '0), "incstp");
		finishTest("register ops", e0);
	endtask

	task automatic testLoadStore();
		int e0;
		e0 = errCount;
		runLoad(LDADDR_1, P_GSP, REG_ADDR, "ldaddr");
		runLoad(LDAC_1, P_GSP, REG_AC, "ldac");
		runLoad(LDMULR_1, P_GSP, REG_MULR, "ldmulr");
		runLoad(LDRP_1, P_RP, REG_MULR, "ldrp");
		runLoad(LDCP_1, P_CP, REG_AC, "ldcp");
		runOp(STSP_1, mkBus(ALU_NONE, BS_AC, P_STP, MEM_WRITE), '0, "stsp");
		finishTest("loads and store", e0);
	endtask

	task automatic testAluMoves();
		int e0;
		e0 = errCount;
		runOp(ADD, mkBus(ALU_ADD, BS_ADDR, P_GSP, MEM_IDLE), '0, "add");
		runOp(MUL1, mkBus(ALU_MUL, BS_MULR, P_GSP, MEM_IDLE), '0, "mul1");
		runOp(MUL2, mkBus(ALU_MUL, BS_MV, P_GSP, MEM_IDLE), '0, "mul2");
		runOp(DIV, mkBus(ALU_DIV, BS_WV, P_GSP, MEM_IDLE), '0, "div");
		runOp(MOD, mkBus(ALU_MOD, BS_WV, P_GSP, MEM_IDLE), '0, "mod");
		runOp(MSTP, IdleBus, mkEn(bitOf(REG_STP), '0, '0), "mstp");
		runOp(MRP, IdleBus, mkEn(bitOf(REG_RP), '0, '0), "mrp");
		runOp(MCP, IdleBus, mkEn(bitOf(REG_CP), '0, '0), "mcp");
		runOp(MWV, IdleBus, mkEn(bitOf(REG_WV), '0, '0), "mwv");
		runOp(MEOPC, IdleBus, mkEn(bitOf(REG_EOPC), '0, '0), "meopc");
		runOp(MADDR, IdleBus, mkEn(bitOf(REG_ADDR), '0, '0), "maddr");
		runOp(MCID, IdleBus, mkEn(bitOf(REG_CID), '0, '0), "mcid");
		runOp(MMV, IdleBus, mkEn(bitOf(REG_MV), '0, '0), "mmv");
		runOp(MCIDAC, mkBus(ALU_NONE, BS_CID, P_GSP, MEM_IDLE), mkEn(bitOf(REG_AC), '0, '0),
			"mcidac");
		runOp(MRPAC, mkBus(ALU_NONE, BS_RP, P_GSP, MEM_IDLE), mkEn(bitOf(REG_AC), '0, '0),
			"mrpac");
		runOp(MCPAC, mkBus(ALU_NONE, BS_CP, P_GSP, MEM_IDLE), mkEn(bitOf(REG_AC), '0, '0),
			"mcpac");
		runOp(MSTPAC, mkBus(ALU_NONE, BS_STP, P_GSP, MEM_IDLE), mkEn(bitOf(REG_AC), '0, '0),
			"mstpac");
		finishTest("alu and moves", e0);
	endtask

	task automatic testBranches();
		int e0;
		e0 = errCount;
		runJump(JMPZ1, 1'b1, 1'b0, 1'b1, "jmpz1 taken");
		runJump(JMPZ1, 1'b0, 1'b0, 1'b0, "jmpz1 not taken");
		runJump(JMPZ2, 1'b0, 1'b0, 1'b1, "jmpz2 taken");
		runJump(JMPZ2, 1'b0, 1'b1, 1'b0, "jmpz2 not taken");
		finishTest("branches", e0);
	endtask

	task automatic testHaltUnknown();
		int e0;
		opcodeT junk;
		e0 = errCount;
		startOp(ENDOP, 1'b0, 1'b0);
		repeat (10) begin
			checkBusCtrl(IdleBus, busCtrl, "halt");
			checkRegEn('0, regEn, "halt");
			@(negedge clk);
		end
		applyReset();
		checkBusCtrl(FetchBus, busCtrl, "after halt");
		// 0x80 to 0x8F holds no state.
		junk = 8'h80 | ($random(seed) & 8'h0F);
		runOp(junk, IdleBus, '0, "unknown opcode");
		finishTest("halt and unknown", e0);
	endtask

	initial begin
		rstN = 1'b0;
		ins = 8'h00;
		z1 = 1'b0;
		z2 = 1'b0;
		testFetch();
		testRegOps();
		testLoadStore();
		testAluMoves();
		testBranches();
		testHaltUnknown();
		$display("%0d tests, %0d failed, %0d errors", testCount, failCount, errCount);
		if (errCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+.
isaPkg.sv
ctrlPkg.sv
stateSequencer.sv
microcodeRom.sv
regEnableDecoder.sv
controlUnit.sv
tbControlUnit.sv

/* Bender.yml */
package:
  name: control_unit

sources:
  - files:
      - isaPkg.sv
      - ctrlPkg.sv
      - stateSequencer.sv
      - microcodeRom.sv
      - regEnableDecoder.sv
      - controlUnit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbControlUnit.sv
